// ==== list.f ====
+incdir+sim
src/sched_pkg.sv
src/addr_decoder.sv
src/req_fifo.sv
src/bank_tracker.sv
src/bank_planner.sv
src/cmd_arbiter.sv
src/request_scheduler.sv
sim/tb_request_scheduler.sv

// ==== Bender.yml ====
package:
  name: request_scheduler

sources:
  - src/sched_pkg.sv
  - src/addr_decoder.sv
  - src/req_fifo.sv
  - src/bank_tracker.sv
  - src/bank_planner.sv
  - src/cmd_arbiter.sv
  - src/request_scheduler.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_request_scheduler.sv

// ==== sim/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

    // state as seen by the arbiter in the cycle whose command shows up now
    sched_pkg::req_entry_t          bank_q [sched_pkg::BANKS][$];
    logic [sched_pkg::BANKS-1:0]    open_m;
    logic [sched_pkg::ROW_BITS-1:0] row_m [sched_pkg::BANKS];
    int                             busy_m [sched_pkg::BANKS];
    logic                           ready_prev;
    logic                           pend_valid;   // pushed at this edge, at the head one cycle on
    int                             pend_bank;
    sched_pkg::req_entry_t          pend_req;

    task automatic reset_model();
        for (int b = 0; b < sched_pkg::BANKS; b++) begin
            bank_q[b].delete();
            row_m[b]  = '0;
            busy_m[b] = 0;
        end
        open_m     = '0;
        ready_prev = 1'b0;
        pend_valid = 1'b0;
        pend_bank  = 0;
    endtask

    function automatic int outstanding();
        int n;
        n = pend_valid ? 1 : 0;
        for (int b = 0; b < sched_pkg::BANKS; b++) n += bank_q[b].size();
        return n;
    endfunction

    // what the head request of a bank needs next
    function automatic sched_pkg::cmd_kind_t need_kind(input int b);
        if (!open_m[b]) return sched_pkg::CMD_ACT;
        if (row_m[b] != bank_q[b][0].row) return sched_pkg::CMD_PRE;
        return bank_q[b][0].write ? sched_pkg::CMD_WRITE : sched_pkg::CMD_READ;
    endfunction

    // smallest rank wins, -1 when no bank can take a command
    function automatic int best_rank();
        int best;
        int rank;
        best = -1;
        for (int b = 0; b < sched_pkg::BANKS; b++) begin
            if (bank_q[b].size() != 0 && busy_m[b] == 0) begin
                rank = int'(need_kind(b)) * sched_pkg::BANKS + b;
                if (best < 0 || rank < best) best = rank;
            end
        end
        return best;
    endfunction

    function automatic logic [18:0] cmd_word(input sched_pkg::cmd_kind_t kind,
                                             input sched_pkg::req_entry_t h);
        logic [2:0]  pat;
        logic [12:0] field;
        case (kind)
            sched_pkg::CMD_READ:  pat = 3'b011;
            sched_pkg::CMD_WRITE: pat = 3'b010;
            sched_pkg::CMD_ACT:   pat = 3'b100;
            default:              pat = 3'b001;
        endcase
        if (kind == sched_pkg::CMD_ACT)
            field = {5'b0, h.row};
        else if (kind == sched_pkg::CMD_PRE)
            field = '0;
        else
            field = {9'b0, h.col};
        return {pat, h.bank_group, h.bank, field};
    endfunction

    task automatic check_command(input int exp_rank);
        int                    b;
        sched_pkg::req_entry_t h;
        b = int'({bank_group_out, bank_out});
        cmd_count++;
        if (bank_q[b].size() == 0) begin
            report_failure($sformatf("command %0d went to bank %0d with nothing queued", cmd_out, b));
            return;
        end
        h = bank_q[b][0];
        if (busy_m[b] != 0) begin
            report_failure($sformatf("command to bank %0d with %0d busy cycles left", b, busy_m[b]));
        end
        if (exp_rank >= 0 && exp_rank != int'(cmd_out) * sched_pkg::BANKS + b) begin
            value_mismatch("priority", exp_rank, int'(cmd_out) * sched_pkg::BANKS + b);
        end
        case (cmd_out)
            sched_pkg::CMD_ACT: begin
                if (open_m[b]) report_failure($sformatf("activate to open bank %0d", b));
                if (row_out !== h.row) value_mismatch("act_row", h.row, row_out);
            end
            sched_pkg::CMD_PRE: begin
                if (!open_m[b] || row_m[b] == h.row) begin
                    report_failure($sformatf("precharge to bank %0d without a row miss", b));
                end
            end
            default: begin
                if (!open_m[b] || row_m[b] != h.row) begin
                    report_failure($sformatf("read or write to bank %0d not open on its row", b));
                end
                if (row_out !== h.row) value_mismatch("rw_row", h.row, row_out);
                if (col_out !== h.col) value_mismatch("rw_col", h.col, col_out);
                if ((cmd_out == sched_pkg::CMD_WRITE) !== h.write) begin
                    value_mismatch("write_flag", h.write, cmd_out == sched_pkg::CMD_WRITE);
                end
                if (data_out !== (h.write ? h.data : '0)) begin
                    value_mismatch("data", h.write ? h.data : '0, data_out);
                end
            end
        endcase
        if (addr_out !== cmd_word(cmd_out, h)) value_mismatch("addr_word", cmd_word(cmd_out, h), addr_out);
        if (cmd_out == sched_pkg::CMD_ACT) begin
            open_m[b] = 1'b1;
            row_m[b]  = h.row;
        end else if (cmd_out == sched_pkg::CMD_PRE) begin
            open_m[b] = 1'b0;
        end else begin
            void'(bank_q[b].pop_front());   // request retired
        end
    endtask

    task automatic step_model();
        int exp_rank;
        int ob;
        int ab;
        exp_rank = ready_prev ? best_rank() : -1;
        if (valid_out === 1'b1 && !ready_prev) begin
            report_failure("command issued after a cycle without a slot");
        end else if (valid_out !== (exp_rank >= 0)) begin
            value_mismatch("issue", exp_rank >= 0, valid_out);
        end
        ob = int'({bank_group_out, bank_out});
        if (valid_out === 1'b1)
            check_command(exp_rank);
        else if (addr_out !== '1)
            value_mismatch("idle_addr", 19'h7ffff, addr_out);
        // busy timers move to the next decision cycle
        for (int b = 0; b < sched_pkg::BANKS; b++) begin
            if (busy_m[b] != 0) busy_m[b]--;
        end
        if (valid_out === 1'b1 && cmd_out == sched_pkg::CMD_ACT) busy_m[ob] = sched_pkg::ACT_LATENCY;
        if (valid_out === 1'b1 && cmd_out == sched_pkg::CMD_PRE) busy_m[ob] = sched_pkg::PRE_LATENCY;
        if (pend_valid) bank_q[pend_bank].push_back(pend_req);
        pend_valid = 1'b0;
        ab = int'(addr_in[6:4]);
        if (full_out !== (bank_q[ab].size() == sched_pkg::QUEUE_DEPTH)) begin
            value_mismatch("full", bank_q[ab].size() == sched_pkg::QUEUE_DEPTH, full_out);
        end
        if (valid_in && bank_q[ab].size() < sched_pkg::QUEUE_DEPTH) begin
            pend_valid = 1'b1;
            pend_bank  = ab;
            pend_req   = '{row: addr_in[14:7], col: addr_in[3:0], bank_group: addr_in[6],
                           bank: addr_in[5:4], write: write_in, data: data_in};
        end
        ready_prev = cmd_ready;
    endtask

`endif

// ==== sim/tb_request_scheduler.sv ====
`timescale 1ns/1ps

module tb_request_scheduler;

    localparam int STIM_CYCLES  = 800;
    localparam int DRAIN_CYCLES = 2000;

    logic                            clk_in;
    logic                            rst_in;
    logic [sched_pkg::ADDR_BITS-1:0] addr_in;
    logic                            valid_in;
    logic                            write_in;
    logic [sched_pkg::DATA_BITS-1:0] data_in;
    logic                            cmd_ready;
    logic                            full_out;
    logic                            valid_out;
    sched_pkg::cmd_kind_t            cmd_out;
    logic [sched_pkg::ADDR_BITS-1:0] addr_out;
    logic [sched_pkg::BG_BITS-1:0]   bank_group_out;
    logic [sched_pkg::BA_BITS-1:0]   bank_out;
    logic [sched_pkg::ROW_BITS-1:0]  row_out;
    logic [sched_pkg::COL_BITS-1:0]  col_out;
    logic [sched_pkg::DATA_BITS-1:0] data_out;

    logic [31:0] lcg_state;
    logic        checking;     // model runs only once reset is released
    int          value_errors;
    int          other_errors;
    int          cmd_count;
    int          cyc;

    request_scheduler dut0 (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .addr_in        (addr_in),
        .valid_in       (valid_in),
        .write_in       (write_in),
        .data_in        (data_in),
        .cmd_ready      (cmd_ready),
        .full_out       (full_out),
        .valid_out      (valid_out),
        .cmd_out        (cmd_out),
        .addr_out       (addr_out),
        .bank_group_out (bank_group_out),
        .bank_out       (bank_out),
        .row_out        (row_out),
        .col_out        (col_out),
        .data_out       (data_out)
    );

    task automatic value_mismatch(input string name, input logic [63:0] expected,
                                  input logic [63:0] actual);
        value_errors++;
        $display("FAILED %s expected %0h actual %0h", name, expected, actual);
    endtask

    task automatic report_failure(input string what);
        other_errors++;
        $display("ERROR: %s", what);
    endtask

    `include "tb_model.svh"

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic drive_random();
        logic [31:0] r1;
        logic [31:0] r2;
        logic [7:0]  row;
        r1 = lcg_next();
        r2 = lcg_next();
        valid_in  = (r1[31:16] % 3) == 0;   // roughly one cycle in three
        cmd_ready = r1[15:14] != 2'b00;
        write_in  = r2[18];
        // few rows so that hits and misses both happen
        case (r2[31:30])
            2'd0:    row = 8'h00;
            2'd1:    row = 8'h5a;
            2'd2:    row = 8'h81;
            default: row = 8'hfe;
        endcase
        addr_in = {r2[22:19], row, r2[29:27], r2[26:23]};   // top nibble is ignored
        data_in = lcg_next();
    endtask

    task automatic check_reset_idle();
        if (valid_out !== 1'b0) value_mismatch("reset_valid", 0, valid_out);
        if (full_out !== 1'b0) value_mismatch("reset_full", 0, full_out);
        if (addr_out !== '1) value_mismatch("reset_addr", 19'h7ffff, addr_out);
    endtask

    initial begin
        clk_in = 1'b0;
        forever begin
            #20 clk_in = ~clk_in;
        end
    end

    always @(posedge clk_in) begin
        if (checking) step_model();
    end

    initial begin
        lcg_state    = 32'hf8d1_aca7;
        rst_in       = 1'b1;
        addr_in      = '0;
        valid_in     = 1'b0;
        write_in     = 1'b0;
        data_in      = '0;
        cmd_ready    = 1'b0;
        checking     = 1'b0;
        value_errors = 0;
        other_errors = 0;
        cmd_count    = 0;
        reset_model();
        repeat (2) begin
            @(negedge clk_in);
            check_reset_idle();
        end
        rst_in   = 1'b0;
        checking = 1'b1;
        @(posedge clk_in);
        check_reset_idle();   // first cycle out of reset is still idle
        for (int i = 0; i < STIM_CYCLES; i++) begin
            @(negedge clk_in);
            drive_random();
        end
        @(negedge clk_in);
        valid_in  = 1'b0;
        cmd_ready = 1'b1;
        cyc = 0;
        while (outstanding() != 0 && cyc < DRAIN_CYCLES) begin
            @(negedge clk_in);
            cyc++;
        end
        if (outstanding() != 0) begin
            report_failure($sformatf("drain timed out with %0d requests unserved",
                                     outstanding()));
        end
        repeat (4) @(negedge clk_in);   // nothing more may be issued
        $display("errors: %0d wrong values, %0d other failures, %0d commands checked",
                 value_errors, other_errors, cmd_count);
        if (value_errors == 0 && other_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== src/request_scheduler.sv ====
`timescale 1ns/1ps

module request_scheduler (
    input  logic                            clk_in,
    input  logic                            rst_in,
    input  logic [sched_pkg::ADDR_BITS-1:0] addr_in,
    input  logic                            valid_in,   // one-cycle strobe
    input  logic                            write_in,
    input  logic [sched_pkg::DATA_BITS-1:0] data_in,
    input  logic                            cmd_ready,  // controller offers a slot
    output logic                            full_out,
    output logic                            valid_out,
    output sched_pkg::cmd_kind_t            cmd_out,
    output logic [sched_pkg::ADDR_BITS-1:0] addr_out,
    output logic [sched_pkg::BG_BITS-1:0]   bank_group_out,
    output logic [sched_pkg::BA_BITS-1:0]   bank_out,
    output logic [sched_pkg::ROW_BITS-1:0]  row_out,
    output logic [sched_pkg::COL_BITS-1:0]  col_out,
    output logic [sched_pkg::DATA_BITS-1:0] data_out
);

    logic [sched_pkg::ROW_BITS-1:0]  dec_row;
    logic [sched_pkg::COL_BITS-1:0]  dec_col;
    logic [sched_pkg::BG_BITS-1:0]   dec_bank_group;
    logic [sched_pkg::BA_BITS-1:0]   dec_bank;
    logic [sched_pkg::BANK_BITS-1:0] dec_bank_idx;
    sched_pkg::req_entry_t           new_req;

    logic [sched_pkg::BANKS-1:0]                         fifo_push;
    logic [sched_pkg::BANKS-1:0]                         fifo_pop;
    logic [sched_pkg::BANKS-1:0]                         fifo_not_empty;
    logic [sched_pkg::BANKS-1:0]                         fifo_full;
    sched_pkg::req_entry_t [sched_pkg::BANKS-1:0]        heads;
    logic [sched_pkg::BANKS-1:0]                         row_open;
    logic [sched_pkg::BANKS-1:0][sched_pkg::ROW_BITS-1:0] open_row;
    logic [sched_pkg::BANKS-1:0]                         busy;
    logic [sched_pkg::BANKS-1:0]                         cand_valid;
    sched_pkg::cmd_kind_t [sched_pkg::BANKS-1:0]         cand_kind;
    logic [sched_pkg::BANKS-1:0]                         grant;

    logic                            issue_valid;
    sched_pkg::cmd_kind_t            issue_kind;
    logic [sched_pkg::BANK_BITS-1:0] issue_bank;
    logic [sched_pkg::ROW_BITS-1:0]  issue_row;
    logic                            issue_rw;

    addr_decoder u_decoder (
        .addr_in    (addr_in),
        .row        (dec_row),
        .col        (dec_col),
        .bank_group (dec_bank_group),
        .bank       (dec_bank),
        .bank_idx   (dec_bank_idx)
    );

    assign new_req = '{
        row:        dec_row,
        col:        dec_col,
        bank_group: dec_bank_group,
        bank:       dec_bank,
        write:      write_in,
        data:       data_in
    };

    // refusal is per bank, so only the addressed queue matters
    assign full_out = fifo_full[dec_bank_idx];

    // only reads and writes retire a queue entry
    assign issue_rw = (issue_kind == sched_pkg::CMD_READ) ||
                      (issue_kind == sched_pkg::CMD_WRITE);

    for (genvar b = 0; b < sched_pkg::BANKS; b++) begin : g_bank
        assign fifo_push[b] = valid_in && !fifo_full[b] &&
                              (dec_bank_idx == sched_pkg::BANK_BITS'(b));
        assign fifo_pop[b]  = grant[b] && issue_rw;

        req_fifo #(
            .payload_t (sched_pkg::req_entry_t)
        ) u_fifo (
            .clk_in    (clk_in),
            .rst_in    (rst_in),
            .push      (fifo_push[b]),
            .push_data (new_req),
            .pop       (fifo_pop[b]),
            .head      (heads[b]),
            .not_empty (fifo_not_empty[b]),
            .full      (fifo_full[b])
        );

        bank_planner u_planner (
            .head_valid (fifo_not_empty[b]),
            .head       (heads[b]),
            .row_open   (row_open[b]),
            .open_row   (open_row[b]),
            .busy       (busy[b]),
            .cand_valid (cand_valid[b]),
            .cand_kind  (cand_kind[b])
        );
    end

    bank_tracker u_tracker (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .issue_valid (issue_valid),
        .issue_kind  (issue_kind),
        .issue_bank  (issue_bank),
        .issue_row   (issue_row),
        .row_open    (row_open),
        .open_row    (open_row),
        .busy        (busy)
    );

    cmd_arbiter u_arbiter (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .cmd_ready      (cmd_ready),
        .cand_valid     (cand_valid),
        .cand_kind      (cand_kind),
        .heads          (heads),
        .grant          (grant),
        .issue_valid    (issue_valid),
        .issue_kind     (issue_kind),
        .issue_bank     (issue_bank),
        .issue_row      (issue_row),
        .valid_out      (valid_out),
        .cmd_out        (cmd_out),
        .addr_out       (addr_out),
        .bank_group_out (bank_group_out),
        .bank_out       (bank_out),
        .row_out        (row_out),
        .col_out        (col_out),
        .data_out       (data_out)
    );

endmodule

// ==== src/cmd_arbiter.sv ====
`timescale 1ns/1ps

module cmd_arbiter (
    input  logic                                   clk_in,
    input  logic                                   rst_in,
    input  logic                                   cmd_ready,
    input  logic [sched_pkg::BANKS-1:0]            cand_valid,
    input  sched_pkg::cmd_kind_t [sched_pkg::BANKS-1:0]  cand_kind,
    input  sched_pkg::req_entry_t [sched_pkg::BANKS-1:0] heads,
    output logic [sched_pkg::BANKS-1:0]            grant,
    output logic                                   issue_valid,
    output sched_pkg::cmd_kind_t                   issue_kind,
    output logic [sched_pkg::BANK_BITS-1:0]        issue_bank,
    output logic [sched_pkg::ROW_BITS-1:0]         issue_row,
    output logic                                   valid_out,
    output sched_pkg::cmd_kind_t                   cmd_out,
    output logic [sched_pkg::ADDR_BITS-1:0]        addr_out,
    output logic [sched_pkg::BG_BITS-1:0]          bank_group_out,
    output logic [sched_pkg::BA_BITS-1:0]          bank_out,
    output logic [sched_pkg::ROW_BITS-1:0]         row_out,
    output logic [sched_pkg::COL_BITS-1:0]         col_out,
    output logic [sched_pkg::DATA_BITS-1:0]        data_out
);

    logic                                found;
    logic [sched_pkg::BANK_BITS-1:0]     sel_bank;
    sched_pkg::cmd_kind_t                sel_kind;
    sched_pkg::req_entry_t               sel_head;
    logic [sched_pkg::PAT_BITS-1:0]      pattern;
    logic [sched_pkg::CMD_FIELD_BITS-1:0] field;
    logic [sched_pkg::ADDR_BITS-1:0]     next_addr;

    // kind first, then lowest bank index within the kind
    always_comb begin
        found    = 1'b0;
        sel_bank = '0;
        sel_kind = sched_pkg::CMD_READ;
        if (cmd_ready) begin
            for (int k = 0; k < sched_pkg::NUM_KINDS; k++) begin
                for (int b = 0; b < sched_pkg::BANKS; b++) begin
                    if (!found && cand_valid[b] &&
                        cand_kind[b] == sched_pkg::cmd_kind_t'(k)) begin
                        found    = 1'b1;
                        sel_bank = sched_pkg::BANK_BITS'(b);
                        sel_kind = sched_pkg::cmd_kind_t'(k);
                    end
                end
            end
        end
    end

    always_comb begin
        grant = '0;
        if (found) begin
            grant[sel_bank] = 1'b1;   // one-hot
        end
    end

    assign sel_head    = heads[sel_bank];
    assign issue_valid = found;
    assign issue_kind  = sel_kind;
    assign issue_bank  = sel_bank;
    assign issue_row   = sel_head.row;

    // command word fields
    always_comb begin
        case (sel_kind)
            sched_pkg::CMD_READ: begin
                pattern = sched_pkg::PAT_READ;
                field   = sched_pkg::CMD_FIELD_BITS'(sel_head.col);
            end
            sched_pkg::CMD_WRITE: begin
                pattern = sched_pkg::PAT_WRITE;
                field   = sched_pkg::CMD_FIELD_BITS'(sel_head.col);
            end
            sched_pkg::CMD_ACT: begin
                pattern = sched_pkg::PAT_ACT;
                field   = sched_pkg::CMD_FIELD_BITS'(sel_head.row);
            end
            default: begin
                pattern = sched_pkg::PAT_PRE;
                field   = '0;   // precharge carries no address
            end
        endcase
    end

    assign next_addr = found ? {pattern, sel_head.bank_group, sel_head.bank, field} : '1;

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            valid_out <= 1'b0;
            addr_out  <= '1;   // all ones means idle
        end else begin
            valid_out <= found;
            addr_out  <= next_addr;
        end
    end

    // fields hold their last command between issues
    always_ff @(posedge clk_in) begin
        if (found) begin
            cmd_out        <= sel_kind;
            bank_group_out <= sel_head.bank_group;
            bank_out       <= sel_head.bank;
            row_out        <= sel_head.row;
            col_out        <= sel_head.col;
            data_out       <= (sel_kind == sched_pkg::CMD_WRITE) ? sel_head.data : '0;
        end
    end

endmodule

// ==== src/bank_planner.sv ====
`timescale 1ns/1ps

module bank_planner (
    input  logic                          head_valid,
    input  sched_pkg::req_entry_t         head,
    input  logic                          row_open,
    input  logic [sched_pkg::ROW_BITS-1:0] open_row,
    input  logic                          busy,
    output logic                          cand_valid,
    output sched_pkg::cmd_kind_t          cand_kind
);

    logic row_hit;

    assign row_hit = row_open && (open_row == head.row);

    // nothing to offer with an empty queue or a bank still settling
    assign cand_valid = head_valid && !busy;

    always_comb begin
        cand_kind = sched_pkg::CMD_READ;
        if (!row_open) begin
            cand_kind = sched_pkg::CMD_ACT;   // closed bank needs the row first
        end else if (!row_hit) begin
            cand_kind = sched_pkg::CMD_PRE;   // wrong row open, close it
        end else if (head.write) begin
            cand_kind = sched_pkg::CMD_WRITE;
        end else begin
            cand_kind = sched_pkg::CMD_READ;
        end
    end

endmodule

// ==== src/bank_tracker.sv ====
`timescale 1ns/1ps

module bank_tracker (
    input  logic                                                clk_in,
    input  logic                                                rst_in,
    input  logic                                                issue_valid,
    input  sched_pkg::cmd_kind_t                                issue_kind,
    input  logic [sched_pkg::BANK_BITS-1:0]                     issue_bank,
    input  logic [sched_pkg::ROW_BITS-1:0]                      issue_row,
    output logic [sched_pkg::BANKS-1:0]                         row_open,
    output logic [sched_pkg::BANKS-1:0][sched_pkg::ROW_BITS-1:0] open_row,
    output logic [sched_pkg::BANKS-1:0]                         busy
);

    logic [sched_pkg::TIMER_BITS-1:0] cnt [sched_pkg::BANKS];
    logic [sched_pkg::BANKS-1:0] hit;   // bank addressed by the issued command

    always_comb begin
        for (int b = 0; b < sched_pkg::BANKS; b++) begin
            hit[b]  = issue_valid && (issue_bank == sched_pkg::BANK_BITS'(b));
            busy[b] = (cnt[b] != '0);
        end
    end

    // open flag and countdown per bank
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            row_open <= '0;
            for (int b = 0; b < sched_pkg::BANKS; b++) begin
                cnt[b] <= '0;
            end
        end else begin
            for (int b = 0; b < sched_pkg::BANKS; b++) begin
                if (hit[b] && issue_kind == sched_pkg::CMD_ACT) begin
                    row_open[b] <= 1'b1;
                    cnt[b]      <= sched_pkg::TIMER_BITS'(sched_pkg::ACT_LATENCY);
                end else if (hit[b] && issue_kind == sched_pkg::CMD_PRE) begin
                    row_open[b] <= 1'b0;
                    cnt[b]      <= sched_pkg::TIMER_BITS'(sched_pkg::PRE_LATENCY);
                end else if (cnt[b] != '0) begin
                    cnt[b] <= cnt[b] - 1'b1;   // counts down in parallel for all banks
                end
            end
        end
    end

    // the row is only meaningful while the open flag is set
    always_ff @(posedge clk_in) begin
        for (int b = 0; b < sched_pkg::BANKS; b++) begin
            if (hit[b] && issue_kind == sched_pkg::CMD_ACT) begin
                open_row[b] <= issue_row;
            end
        end
    end

endmodule

// ==== src/req_fifo.sv ====
`timescale 1ns/1ps

module req_fifo #(
    parameter type payload_t = logic
) (
    input  logic     clk_in,
    input  logic     rst_in,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     not_empty,
    output logic     full
);

    payload_t mem [sched_pkg::QUEUE_DEPTH];
    logic [sched_pkg::QPTR_BITS-1:0] wr_ptr;
    logic [sched_pkg::QPTR_BITS-1:0] rd_ptr;
    logic [sched_pkg::QCNT_BITS-1:0] count;
    logic do_push;
    logic do_pop;

    assign not_empty = (count != '0);
    assign full      = (count == sched_pkg::QCNT_BITS'(sched_pkg::QUEUE_DEPTH));
    assign do_push   = push && !full;   // a push into a full queue is dropped
    assign do_pop    = pop && not_empty;
    assign head      = mem[rd_ptr];     // oldest entry

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                if (wr_ptr == sched_pkg::QPTR_BITS'(sched_pkg::QUEUE_DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (do_pop) begin
                if (rd_ptr == sched_pkg::QPTR_BITS'(sched_pkg::QUEUE_DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            // push and pop together leave the count as it is
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

// ==== src/addr_decoder.sv ====
`timescale 1ns/1ps

module addr_decoder (
    input  logic [sched_pkg::ADDR_BITS-1:0] addr_in,
    output logic [sched_pkg::ROW_BITS-1:0]  row,
    output logic [sched_pkg::COL_BITS-1:0]  col,
    output logic [sched_pkg::BG_BITS-1:0]   bank_group,
    output logic [sched_pkg::BA_BITS-1:0]   bank,
    output logic [sched_pkg::BANK_BITS-1:0] bank_idx
);

    // bits above the row field are not used
    assign col        = addr_in[0 +: sched_pkg::COL_BITS];
    assign bank       = addr_in[sched_pkg::BA_LSB +: sched_pkg::BA_BITS];
    assign bank_group = addr_in[sched_pkg::BG_LSB +: sched_pkg::BG_BITS];
    assign row        = addr_in[sched_pkg::ROW_LSB +: sched_pkg::ROW_BITS];

    // flat index selects the bank queue, group bits on top
    assign bank_idx = {bank_group, bank};

endmodule

// ==== src/sched_pkg.sv ====
package sched_pkg;

    // bus and DRAM geometry
    localparam int ADDR_BITS = 19;   // also the width of the command word
    localparam int ROW_BITS  = 8;
    localparam int COL_BITS  = 4;
    localparam int BG_BITS   = 1;
    localparam int BA_BITS   = 2;
    localparam int BANK_BITS = BG_BITS + BA_BITS;
    localparam int BANKS     = 1 << BANK_BITS;
    localparam int DATA_BITS = 32;

    // bit positions of the address fields, column at the bottom
    localparam int BA_LSB  = COL_BITS;
    localparam int BG_LSB  = BA_LSB + BA_BITS;
    localparam int ROW_LSB = BG_LSB + BG_BITS;

    // per-bank queue
    localparam int QUEUE_DEPTH = 4;
    localparam int QPTR_BITS   = $clog2(QUEUE_DEPTH);
    localparam int QCNT_BITS   = $clog2(QUEUE_DEPTH + 1);

    // bank timing, in controller cycles
    localparam int ACT_LATENCY = 8;
    localparam int PRE_LATENCY = 5;
    localparam int TIMER_BITS  = $clog2(ACT_LATENCY + 1);

    // command word layout: pattern, bank group, bank, row or column field
    localparam int          PAT_BITS       = 3;
    localparam int          CMD_FIELD_BITS = ADDR_BITS - PAT_BITS - BANK_BITS;
    localparam logic [2:0]  PAT_READ       = 3'b011;
    localparam logic [2:0]  PAT_WRITE      = 3'b010;
    localparam logic [2:0]  PAT_ACT        = 3'b100;
    localparam logic [2:0]  PAT_PRE        = 3'b001;

    // kinds in priority order, lowest value wins
    localparam int NUM_KINDS = 4;

    typedef enum logic [1:0] {
        CMD_READ  = 2'd0,
        CMD_WRITE = 2'd1,
        CMD_ACT   = 2'd2,
        CMD_PRE   = 2'd3
    } cmd_kind_t;

    typedef struct packed {
        logic [ROW_BITS-1:0]  row;
        logic [COL_BITS-1:0]  col;
        logic [BG_BITS-1:0]   bank_group;
        logic [BA_BITS-1:0]   bank;
        logic                 write;
        logic [DATA_BITS-1:0] data;
    } req_entry_t;

endpackage
